//--- rtl/cdc_fifo_cfg_pkg.sv
// Configuration constants of the CDC FIFO: depth, width, synchronizer stages, derived widths
`default_nettype none

package cdc_fifo_cfg_pkg;

  // Number of RAM entries, which is also the number of credits issued after reset
  localparam int DEPTH = 8;

  // Payload width of one FIFO word
  localparam int WIDTH = 16;

  // Flops of the destination clock in each Gray count crossing
  localparam int SYNC_STAGES = 2;

  // RAM address width
  localparam int ADDR_W = $clog2(DEPTH);

  // Counts carry one extra bit so that full and empty differ, they wrap at 2*DEPTH
  localparam int COUNT_W = ADDR_W + 1;

  // DEPTH sized to a count, for slot arithmetic and the credit counter load
  localparam logic [COUNT_W-1:0] DEPTH_C = COUNT_W'(DEPTH);

endpackage : cdc_fifo_cfg_pkg

`default_nettype wire

//--- rtl/cdc_fifo_types_pkg.sv
// Interface structs of the CDC FIFO: RAM write port and pop-side output
`default_nettype none

package cdc_fifo_types_pkg;

  // ----------------------------------------------------------------------
  // RAM write port, driven from the push domain
  // ----------------------------------------------------------------------

  // One write into the 1R1W storage
  // The write lands at the push_clk edge that samples it
  typedef struct packed {
    logic                                valid;
    logic [cdc_fifo_cfg_pkg::ADDR_W-1:0] addr;
    logic [cdc_fifo_cfg_pkg::WIDTH-1:0]  data;
  } ram_wr_t;

  // ----------------------------------------------------------------------
  // Pop-side output, ready/valid in the pop domain
  // ----------------------------------------------------------------------

  // Valid and data hold steady while the receiver is not ready
  typedef struct packed {
    logic                               valid;
    logic [cdc_fifo_cfg_pkg::WIDTH-1:0] data;
  } pop_out_t;

endpackage : cdc_fifo_types_pkg

`default_nettype wire

//--- rtl/cdc_fifo_gray_sync.sv
// Gray-coded count crossing: source Gray register, destination synchronizer, Gray to binary
`timescale 1ns/100ps
`default_nettype none

module cdc_fifo_gray_sync (
  input  logic                                 src_clk,
  input  logic                                 dst_clk,
  input  logic                                 rst_n,
  input  logic [cdc_fifo_cfg_pkg::COUNT_W-1:0] src_count,
  output logic [cdc_fifo_cfg_pkg::COUNT_W-1:0] dst_count
);

  logic [cdc_fifo_cfg_pkg::COUNT_W-1:0] src_gray_q;
  logic [cdc_fifo_cfg_pkg::SYNC_STAGES-1:0][cdc_fifo_cfg_pkg::COUNT_W-1:0] sync_q;
  logic [cdc_fifo_cfg_pkg::COUNT_W-1:0] dst_gray;

  // The count steps by at most one per source cycle, so its Gray form flips one bit
  // The register keeps the conversion glitches away from the crossing
  always_ff @(posedge src_clk or negedge rst_n) begin
    if (!rst_n) begin
      src_gray_q <= '0;
    end else begin
      src_gray_q <= src_count ^ (src_count >> 1);
    end
  end

  // Synchronizer chain in the destination clock
  // Both sides hold zero counts until their own reset releases, so the raw rst_n is safe here
  always_ff @(posedge dst_clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[cdc_fifo_cfg_pkg::SYNC_STAGES-2:0], src_gray_q};
    end
  end

  assign dst_gray = sync_q[cdc_fifo_cfg_pkg::SYNC_STAGES-1];

  // Gray to binary, each binary bit is the XOR of all Gray bits at and above it
  for (genvar i = 0; i < cdc_fifo_cfg_pkg::COUNT_W; i++) begin : g_bin
    assign dst_count[i] = ^(dst_gray >> i);
  end

endmodule : cdc_fifo_gray_sync

`default_nettype wire

//--- rtl/cdc_fifo_push_ctrl.sv
// Push-side controller: reset synchronizer, write pointer, RAM write, slot count, credit issue
`timescale 1ns/100ps
`default_nettype none

module cdc_fifo_push_ctrl (
  input  logic                                 push_clk,
  input  logic                                 rst_n,
  input  logic                                 push_valid,
  input  logic [cdc_fifo_cfg_pkg::WIDTH-1:0]   push_data,
  input  logic [cdc_fifo_cfg_pkg::COUNT_W-1:0] pop_count_sync,
  output logic [cdc_fifo_cfg_pkg::COUNT_W-1:0] push_count,
  output cdc_fifo_types_pkg::ram_wr_t          ram_wr,
  output logic                                 push_credit,
  output logic [cdc_fifo_cfg_pkg::COUNT_W-1:0] push_slots
);

  logic [1:0]                           rst_sync_q;
  logic                                 push_rst_n;
  logic [cdc_fifo_cfg_pkg::COUNT_W-1:0] pop_seen_q;
  logic [cdc_fifo_cfg_pkg::COUNT_W-1:0] pop_delta;
  logic [cdc_fifo_cfg_pkg::COUNT_W-1:0] owed_q;
  logic [cdc_fifo_cfg_pkg::COUNT_W-1:0] owed_next;
  logic                                 credit_issue;

  // Reset asserts at once and releases two push_clk edges later
  always_ff @(posedge push_clk or negedge rst_n) begin
    if (!rst_n) begin
      rst_sync_q <= 2'b00;
    end else begin
      rst_sync_q <= {rst_sync_q[0], 1'b1};
    end
  end

  assign push_rst_n = rst_sync_q[1];

  // ----------------------------------------------------------------------
  // Write side
  // ----------------------------------------------------------------------

  // The low bits of the push count are the write pointer
  // A push is accepted without a check, the sender's credit guarantees room
  assign ram_wr.valid = push_valid;
  assign ram_wr.addr  = push_count[cdc_fifo_cfg_pkg::ADDR_W-1:0];
  assign ram_wr.data  = push_data;

  // Occupancy as seen from here is pessimistic, since pops arrive late through the sync
  assign push_slots = cdc_fifo_cfg_pkg::DEPTH_C - (push_count - pop_count_sync);

  // ----------------------------------------------------------------------
  // Credit return
  // ----------------------------------------------------------------------

  // Pops newly seen through the crossing, may be more than one per push cycle
  assign pop_delta    = pop_count_sync - pop_seen_q;
  assign credit_issue = (owed_q != '0);

  // Owed credits never exceed DEPTH, so the sum cannot wrap
  always_comb begin
    owed_next = owed_q + pop_delta;
    if (credit_issue) begin
      owed_next = owed_next - 1'b1;
    end
  end

  // The owed counter starts at DEPTH, which gives the initial burst of credits
  always_ff @(posedge push_clk or negedge push_rst_n) begin
    if (!push_rst_n) begin
      push_count  <= '0;
      pop_seen_q  <= '0;
      owed_q      <= cdc_fifo_cfg_pkg::DEPTH_C;
      push_credit <= 1'b0;
    end else begin
      if (push_valid) begin
        push_count <= push_count + 1'b1;
      end
      pop_seen_q  <= pop_count_sync;
      owed_q      <= owed_next;
      push_credit <= credit_issue;
    end
  end

endmodule : cdc_fifo_push_ctrl

`default_nettype wire

//--- rtl/cdc_fifo_pop_ctrl.sv
// Pop-side controller: reset synchronizer, read pointer, item count, pop valid, RAM read address
`timescale 1ns/100ps
`default_nettype none

module cdc_fifo_pop_ctrl (
  input  logic                                 pop_clk,
  input  logic                                 rst_n,
  input  logic                                 pop_ready,
  input  logic [cdc_fifo_cfg_pkg::WIDTH-1:0]   pop_rd_data,
  input  logic [cdc_fifo_cfg_pkg::COUNT_W-1:0] push_count_sync,
  output logic [cdc_fifo_cfg_pkg::COUNT_W-1:0] pop_count,
  output logic [cdc_fifo_cfg_pkg::ADDR_W-1:0]  pop_rd_addr,
  output cdc_fifo_types_pkg::pop_out_t         pop_out,
  output logic [cdc_fifo_cfg_pkg::COUNT_W-1:0] pop_items
);

  logic [1:0] rst_sync_q;
  logic       pop_rst_n;
  logic       pop_fire;

  // ----------------------------------------------------------------------
  // Reset synchronizer
  // ----------------------------------------------------------------------

  // Same scheme as the push side, but released on pop_clk
  always_ff @(posedge pop_clk or negedge rst_n) begin
    if (!rst_n) begin
      rst_sync_q <= 2'b00;
    end else begin
      rst_sync_q <= {rst_sync_q[0], 1'b1};
    end
  end

  assign pop_rst_n = rst_sync_q[1];

  // ----------------------------------------------------------------------
  // Status and read path
  // ----------------------------------------------------------------------

  // Items visible here lag the real pushes by the crossing delay
  // Both counts are zero in reset, so pop_items and pop_valid start low
  assign pop_items = push_count_sync - pop_count;

  // The low bits of the pop count address the oldest word
  assign pop_rd_addr = pop_count[cdc_fifo_cfg_pkg::ADDR_W-1:0];

  // RAM read is combinational, so data follows the address in the same cycle
  // A slot cannot be rewritten before its pop returns the credit, so data holds while stalled
  assign pop_out.valid = (pop_items != '0);
  assign pop_out.data  = pop_rd_data;

  // Transfer when valid and ready meet on one edge
  assign pop_fire = pop_out.valid & pop_ready;

  // ----------------------------------------------------------------------
  // Read pointer
  // ----------------------------------------------------------------------

  // Each handshake advances the pointer by one
  // The new count also crosses back to the push side to return a credit
  always_ff @(posedge pop_clk or negedge pop_rst_n) begin
    if (!pop_rst_n) begin
      pop_count <= '0;
    end else if (pop_fire) begin
      pop_count <= pop_count + 1'b1;
    end
  end

endmodule : cdc_fifo_pop_ctrl

`default_nettype wire

//--- rtl/cdc_fifo_ctrl.sv
// CDC FIFO controller: push and pop controllers joined by two Gray count crossings
`timescale 1ns/100ps
`default_nettype none

module cdc_fifo_ctrl (
  input  logic                                 push_clk,
  input  logic                                 pop_clk,
  input  logic                                 rst_n,
  // Push side, credit/valid
  input  logic                                 push_valid,
  input  logic [cdc_fifo_cfg_pkg::WIDTH-1:0]   push_data,
  output logic                                 push_credit,
  output logic [cdc_fifo_cfg_pkg::COUNT_W-1:0] push_slots,
  output cdc_fifo_types_pkg::ram_wr_t          ram_wr,
  // Pop side, ready/valid
  input  logic                                 pop_ready,
  input  logic [cdc_fifo_cfg_pkg::WIDTH-1:0]   pop_rd_data,
  output logic [cdc_fifo_cfg_pkg::ADDR_W-1:0]  pop_rd_addr,
  output cdc_fifo_types_pkg::pop_out_t         pop_out,
  output logic [cdc_fifo_cfg_pkg::COUNT_W-1:0] pop_items
);

  // Counts in their own domain and their copies after the crossing
  logic [cdc_fifo_cfg_pkg::COUNT_W-1:0] push_count;
  logic [cdc_fifo_cfg_pkg::COUNT_W-1:0] pop_count;
  logic [cdc_fifo_cfg_pkg::COUNT_W-1:0] push_count_sync;
  logic [cdc_fifo_cfg_pkg::COUNT_W-1:0] pop_count_sync;

  cdc_fifo_push_ctrl u_push_ctrl (
    .push_clk       (push_clk),
    .rst_n          (rst_n),
    .push_valid     (push_valid),
    .push_data      (push_data),
    .pop_count_sync (pop_count_sync),
    .push_count     (push_count),
    .ram_wr         (ram_wr),
    .push_credit    (push_credit),
    .push_slots     (push_slots)
  );

  // Push count into the pop domain, tells the pop side what it may read
  cdc_fifo_gray_sync u_push2pop_sync (
    .src_clk   (push_clk),
    .dst_clk   (pop_clk),
    .rst_n     (rst_n),
    .src_count (push_count),
    .dst_count (push_count_sync)
  );

  // Pop count into the push domain, drives slots and credit return
  cdc_fifo_gray_sync u_pop2push_sync (
    .src_clk   (pop_clk),
    .dst_clk   (push_clk),
    .rst_n     (rst_n),
    .src_count (pop_count),
    .dst_count (pop_count_sync)
  );

  cdc_fifo_pop_ctrl u_pop_ctrl (
    .pop_clk         (pop_clk),
    .rst_n           (rst_n),
    .pop_ready       (pop_ready),
    .pop_rd_data     (pop_rd_data),
    .push_count_sync (push_count_sync),
    .pop_count       (pop_count),
    .pop_rd_addr     (pop_rd_addr),
    .pop_out         (pop_out),
    .pop_items       (pop_items)
  );

endmodule : cdc_fifo_ctrl

`default_nettype wire

//--- rtl/cdc_fifo_ram.sv
// Flop-based 1R1W FIFO storage, written on push_clk, read combinationally
`timescale 1ns/100ps
`default_nettype none

module cdc_fifo_ram (
  input  logic                                push_clk,
  input  cdc_fifo_types_pkg::ram_wr_t         ram_wr,
  input  logic [cdc_fifo_cfg_pkg::ADDR_W-1:0] pop_rd_addr,
  output logic [cdc_fifo_cfg_pkg::WIDTH-1:0]  pop_rd_data
);

  // One word per FIFO entry
  logic [cdc_fifo_cfg_pkg::WIDTH-1:0] mem_q [cdc_fifo_cfg_pkg::DEPTH];

  // Write port in the push domain, the word is readable one push cycle later
  always_ff @(posedge push_clk) begin
    if (ram_wr.valid) begin
      mem_q[ram_wr.addr] <= ram_wr.data;
    end
  end

  // Read port has no clock, the pop domain samples it only once the
  // word's push count has crossed, long after the write settled
  assign pop_rd_data = mem_q[pop_rd_addr];

endmodule : cdc_fifo_ram

`default_nettype wire

//--- rtl/cdc_fifo_top.sv
// CDC FIFO top level: controller and flop RAM
`timescale 1ns/100ps
`default_nettype none

module cdc_fifo_top (
  input  logic                                 push_clk,
  input  logic                                 pop_clk,
  input  logic                                 rst_n,
  // Push side, one credit strobe per free slot
  input  logic                                 push_valid,
  input  logic [cdc_fifo_cfg_pkg::WIDTH-1:0]   push_data,
  output logic                                 push_credit,
  output logic [cdc_fifo_cfg_pkg::COUNT_W-1:0] push_slots,
  // Pop side, ready/valid
  input  logic                                 pop_ready,
  output cdc_fifo_types_pkg::pop_out_t         pop_out,
  output logic [cdc_fifo_cfg_pkg::COUNT_W-1:0] pop_items
);

  // Storage port between controller and RAM
  cdc_fifo_types_pkg::ram_wr_t         ram_wr;
  logic [cdc_fifo_cfg_pkg::ADDR_W-1:0] pop_rd_addr;
  logic [cdc_fifo_cfg_pkg::WIDTH-1:0]  pop_rd_data;

  cdc_fifo_ctrl u_ctrl (
    .push_clk    (push_clk),
    .pop_clk     (pop_clk),
    .rst_n       (rst_n),
    .push_valid  (push_valid),
    .push_data   (push_data),
    .push_credit (push_credit),
    .push_slots  (push_slots),
    .ram_wr      (ram_wr),
    .pop_ready   (pop_ready),
    .pop_rd_data (pop_rd_data),
    .pop_rd_addr (pop_rd_addr),
    .pop_out     (pop_out),
    .pop_items   (pop_items)
  );

  cdc_fifo_ram u_ram (
    .push_clk    (push_clk),
    .ram_wr      (ram_wr),
    .pop_rd_addr (pop_rd_addr),
    .pop_rd_data (pop_rd_data)
  );

endmodule : cdc_fifo_top

`default_nettype wire

//--- verif/cdc_fifo_asserts.sv
// Concurrent assertions on the CDC FIFO ports and on the Gray registers of both crossings
`timescale 1ns/100ps
`default_nettype none

module cdc_fifo_asserts (
  input logic                                 push_clk,
  input logic                                 pop_clk,
  input logic                                 rst_n,
  input logic                                 push_valid,
  input logic                                 push_credit,
  input logic [cdc_fifo_cfg_pkg::COUNT_W-1:0] push_slots,
  input logic                                 pop_ready,
  input cdc_fifo_types_pkg::pop_out_t         pop_out,
  input logic [cdc_fifo_cfg_pkg::COUNT_W-1:0] push_gray,
  input logic [cdc_fifo_cfg_pkg::COUNT_W-1:0] pop_gray
);

  // A push spends a credit, and a credit is only granted for a slot the push side sees free
  a_push_has_slot: assert property (
    @(posedge push_clk) disable iff (!rst_n) push_valid |-> (push_slots != '0)
  ) else $error("push_valid seen while push_slots is zero");

  // A stalled word keeps its valid and its data until the receiver takes it
  a_pop_hold: assert property (
    @(posedge pop_clk) disable iff (!rst_n)
      (pop_out.valid && !pop_ready) |=> (pop_out.valid && $stable(pop_out.data))
  ) else $error("pop_out changed while stalled");

  // ----------------------------------------------------------------------
  // Reset and crossings
  // ----------------------------------------------------------------------

  // Both strobes stay quiet while reset is held
  a_credit_in_reset: assert property (
    @(posedge push_clk) !rst_n |-> !push_credit
  ) else $error("push_credit high during reset");

  a_valid_in_reset: assert property (
    @(posedge pop_clk) !rst_n |-> !pop_out.valid
  ) else $error("pop_out.valid high during reset");

  // Each Gray register flips one bit at most per source cycle, or the crossing can tear
  a_push_gray_step: assert property (
    @(posedge push_clk) disable iff (!rst_n) $countones(push_gray ^ $past(push_gray)) <= 1
  ) else $error("push count Gray register changed more than one bit");

  a_pop_gray_step: assert property (
    @(posedge pop_clk) disable iff (!rst_n) $countones(pop_gray ^ $past(pop_gray)) <= 1
  ) else $error("pop count Gray register changed more than one bit");

endmodule : cdc_fifo_asserts

// The Gray registers sit inside the two cdc_fifo_gray_sync instances of the controller
bind cdc_fifo_top cdc_fifo_asserts u_asserts (
  .push_clk    (push_clk),
  .pop_clk     (pop_clk),
  .rst_n       (rst_n),
  .push_valid  (push_valid),
  .push_credit (push_credit),
  .push_slots  (push_slots),
  .pop_ready   (pop_ready),
  .pop_out     (pop_out),
  .push_gray   (u_ctrl.u_push2pop_sync.src_gray_q),
  .pop_gray    (u_ctrl.u_pop2push_sync.src_gray_q)
);

`default_nettype wire

//--- verif/cdc_fifo_tb.sv
// CDC FIFO testbench with clocks, reset, credit sender, stalling receiver, scoreboard and timeout
`timescale 1ns/100ps
`default_nettype none

module cdc_fifo_tb;

  typedef logic [cdc_fifo_cfg_pkg::WIDTH-1:0] word_t;

  logic                                 push_clk;
  logic                                 pop_clk;
  logic                                 rst_n;
  logic                                 push_valid;
  word_t                                push_data;
  logic                                 pop_ready;
  logic                                 push_credit;
  logic [cdc_fifo_cfg_pkg::COUNT_W-1:0] push_slots;
  logic [cdc_fifo_cfg_pkg::COUNT_W-1:0] pop_items;
  cdc_fifo_types_pkg::pop_out_t         pop_out;

  // One entry per line of the case file
  int case_start[$];
  int case_count[$];
  int case_stall[$];

  // Words pushed but not yet popped with the oldest first
  word_t scoreboard[$];

  int credits_rcvd = 0;
  int pushes_sent  = 0;
  int words_popped = 0;
  int case_base    = 0;
  int cycles       = 0;
  int cycle_limit  = 200;

  cdc_fifo_top u_cdc_fifo_top (
    .push_clk    (push_clk),
    .pop_clk     (pop_clk),
    .rst_n       (rst_n),
    .push_valid  (push_valid),
    .push_data   (push_data),
    .push_credit (push_credit),
    .push_slots  (push_slots),
    .pop_ready   (pop_ready),
    .pop_out     (pop_out),
    .pop_items   (pop_items)
  );

  // ----------------------------------------------------------------------
  // Clocks, credit counter and timeout
  // ----------------------------------------------------------------------

  // Both clocks run at 8 ns and pop_clk trails by 3 ns so that edges never coincide
  initial begin
    push_clk = 1'b0;
    forever #4 push_clk = ~push_clk;
  end

  initial begin
    pop_clk = 1'b0;
    #3;
    forever #4 pop_clk = ~pop_clk;
  end

  // A credit strobe lasts one push cycle, so the falling edge sees it settled
  initial begin
    forever begin
      @(negedge push_clk);
      if (push_credit) begin
        credits_rcvd = credits_rcvd + 1;
      end
    end
  end

  initial begin
    forever begin
      @(posedge push_clk);
      cycles = cycles + 1;
      if (cycles >= cycle_limit) begin
        end_with_failure("Timeout: the FIFO stopped making progress");
      end
    end
  end

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------

  task automatic end_with_failure(input string reason);
    $display("%s", reason);
    $display("SOME TESTS FAILED");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      end_with_failure($sformatf("Error: %s is 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  // Point in the push cycle where credits, pushes and push_slots have all settled
  task automatic push_mid();
    @(negedge push_clk);
    #1;
  endtask

  // An idle FIFO has every slot free, nothing to pop, and all credits back with the sender
  task automatic check_idle();
    check_value("push_slots", 32'(push_slots), cdc_fifo_cfg_pkg::DEPTH);
    check_value("pop_items", 32'(pop_items), 32'h0);
    check_value("pop_out.valid", 32'(pop_out.valid), 32'h0);
    check_value("credits_received", credits_rcvd, cdc_fifo_cfg_pkg::DEPTH + words_popped);
    check_value("credits_held", credits_rcvd - pushes_sent, cdc_fifo_cfg_pkg::DEPTH);
  endtask

  task automatic wait_credits_home();
    push_mid();
    while (credits_rcvd - pushes_sent != cdc_fifo_cfg_pkg::DEPTH) begin
      push_mid();
    end
    // A stray strobe would show up within a few cycles of the last returned credit
    repeat (cdc_fifo_cfg_pkg::SYNC_STAGES + 4) push_mid();
    check_idle();
  endtask

  // ----------------------------------------------------------------------
  // Case file, sender and receiver
  // ----------------------------------------------------------------------

  // Lines that do not parse as three numbers are comments
  task automatic read_cases();
    int    fd;
    int    rc;
    int    start_v;
    int    count_v;
    int    stall_v;
    string line;
    fd = $fopen("verif/cdc_fifo_cases.txt", "r");
    if (fd == 0) begin
      end_with_failure("Cannot open the case file verif/cdc_fifo_cases.txt");
    end
    while (!$feof(fd)) begin
      rc = $fgets(line, fd);
      if (rc > 0 && $sscanf(line, "%h %d %d", start_v, count_v, stall_v) == 3) begin
        case_start.push_back(start_v);
        case_count.push_back(count_v);
        case_stall.push_back(stall_v);
        cycle_limit = cycle_limit + 40 * count_v;
      end
    end
    $fclose(fd);
    if (case_start.size() == 0) begin
      end_with_failure("The case file holds no test cases");
    end
  endtask

  // Pushes start, start+1, ... one per cycle while a credit is held
  task automatic send_words(input word_t start, input int count);
    int i;
    i = 0;
    while (i < count) begin
      @(posedge push_clk);
      #1;
      if (credits_rcvd - pushes_sent > 0) begin
        push_valid = 1'b1;
        push_data  = start + word_t'(i);
        scoreboard.push_back(start + word_t'(i));
        pushes_sent = pushes_sent + 1;
        i = i + 1;
      end else begin
        push_valid = 1'b0;
      end
    end
    @(posedge push_clk);
    #1;
    push_valid = 1'b0;
  endtask

  // Pops count words and holds pop_ready low for stall percent of the cycles
  task automatic recv_words(input int count, input int stall);
    int    got;
    int    stall_now;
    word_t exp_word;
    got       = 0;
    stall_now = stall;
    if (stall >= 100) begin
      // Nothing pops, so no credit returns and the sender stops after DEPTH words
      push_mid();
      while (credits_rcvd - pushes_sent != 0) begin
        push_mid();
      end
      check_value("pushes_accepted", pushes_sent - case_base, cdc_fifo_cfg_pkg::DEPTH);
      @(negedge pop_clk);
      while (pop_items != cdc_fifo_cfg_pkg::DEPTH_C) begin
        @(negedge pop_clk);
      end
      push_mid();
      check_value("push_slots", 32'(push_slots), 32'h0);
      stall_now = 0;
    end
    while (got < count) begin
      @(posedge pop_clk);
      #1;
      pop_ready = (($urandom % 100) >= 32'(stall_now));
      // The handshake happens at the next rising edge and the falling edge sees it coming
      @(negedge pop_clk);
      if (pop_out.valid && pop_ready) begin
        if (scoreboard.size() == 0) begin
          end_with_failure("The FIFO delivered a word that was never pushed");
        end
        exp_word = scoreboard.pop_front();
        check_value("pop_out.data", 32'(pop_out.data), 32'(exp_word));
        got          = got + 1;
        words_popped = words_popped + 1;
      end
    end
    @(posedge pop_clk);
    #1;
    pop_ready = 1'b0;
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------

  initial begin
    push_valid = 1'b0;
    push_data  = '0;
    pop_ready  = 1'b0;
    rst_n      = 1'b0;
    void'($urandom(32'h193325d8));
    read_cases();
    repeat (16) @(posedge push_clk);
    #1;
    rst_n = 1'b1;

    // The first DEPTH credits arrive unprompted and then the strobe stays quiet
    wait_credits_home();
    repeat (20) @(posedge push_clk);
    push_mid();
    check_idle();

    foreach (case_start[k]) begin
      $display("Case %0d: start 0x%04h, %0d words, pop stall %0d percent",
               k, case_start[k], case_count[k], case_stall[k]);
      case_base = pushes_sent;
      fork
        send_words(word_t'(case_start[k]), case_count[k]);
        recv_words(case_count[k], case_stall[k]);
      join
      wait_credits_home();
    end

    // No stray credit may follow the last case
    repeat (20) @(posedge push_clk);
    push_mid();
    check_idle();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule : cdc_fifo_tb

`default_nettype wire

//--- cdc_fifo.f
rtl/cdc_fifo_cfg_pkg.sv
rtl/cdc_fifo_types_pkg.sv
rtl/cdc_fifo_gray_sync.sv
rtl/cdc_fifo_push_ctrl.sv
rtl/cdc_fifo_pop_ctrl.sv
rtl/cdc_fifo_ctrl.sv
rtl/cdc_fifo_ram.sv
rtl/cdc_fifo_top.sv
verif/cdc_fifo_asserts.sv
verif/cdc_fifo_tb.sv

//--- Makefile
# Verilator build and run of the CDC FIFO testbench

VERILATOR ?= verilator
TOP       ?= cdc_fifo_tb
FILELIST  ?= cdc_fifo.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

.PHONY: sim clean

# Build, run, and fail when the log holds the fail message or the run aborted
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "SOME TESTS FAILED" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verif/cdc_fifo_cases.txt
# start (hex)  word count (dec)  pop stall percent (dec)
# A stall of 100 holds pop_ready low until the sender runs out of credits
0000 8 0
1000 20 0
2000 12 100
3000 40 25
4000 1 0
5000 33 50
6000 16 100
7ff8 24 10
8000 50 75
9000 9 100
a000 64 5
b000 30 60
c000 3 40
fff0 40 30
